// ==== verilog/fp_config.svh ====
`ifndef FP_CONFIG_SVH
`define FP_CONFIG_SVH

// bfloat16 field widths
`define EXP_WIDTH 8
`define MANT_WIDTH 7    // Stored fraction only, hidden bit not counted

// Biased exponent, all ones is reserved for infinity and NaN
`define EXP_BIAS 127

// Extra bits kept below the fraction during alignment
`define GRS_BITS 3      // Guard, round, sticky

`endif

// ==== verilog/bfloatPkg.sv ====
`default_nettype none
`include "fp_config.svh"

// Number format types for bfloat16
package bfloatPkg;

	// Sign, exponent, fraction
	typedef logic [`EXP_WIDTH+`MANT_WIDTH:0] bf16T;

	typedef logic [`EXP_WIDTH-1:0] expT;        // Biased exponent field

	// One spare bit so overflow past all ones is visible
	typedef logic [`EXP_WIDTH:0] expWideT;

	typedef logic [`MANT_WIDTH:0] sigT;         // Hidden one plus fraction

	// Carry, significand, then guard/round/sticky at the bottom
	typedef logic [`MANT_WIDTH+1+`GRS_BITS:0] sumT;

endpackage

`default_nettype wire

// ==== verilog/fpOpPkg.sv ====
`default_nettype none
`include "fp_config.svh"

// Operation level types shared by the adder stages
package fpOpPkg;

	typedef logic [3:0] flagsT;                 // Overflow, underflow, invalid, inexact
	localparam int FLAG_OVERFLOW = 3;
	localparam int FLAG_UNDERFLOW = 2;
	localparam int FLAG_INVALID = 1;
	localparam int FLAG_INEXACT = 0;

	// Alignment distance, anything past the GRS bits is all sticky
	typedef logic [3:0] shiftT;
	localparam shiftT SHIFT_MAX = shiftT'(`MANT_WIDTH + 1 + `GRS_BITS);

	// Result override picked in decode
	typedef logic [1:0] specialT;
	localparam specialT SPEC_NONE = 2'd0;
	localparam specialT SPEC_QNAN = 2'd1;
	localparam specialT SPEC_INF = 2'd2;
	localparam specialT SPEC_ZERO = 2'd3;

endpackage

`default_nettype wire

// ==== verilog/fpAddDecode.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "fp_config.svh"

module fpAddDecode (
	input  wire clk,
	input  wire reset,
	input  wire inValid,
	output logic inReady,
	input  wire bfloatPkg::bf16T a,
	input  wire bfloatPkg::bf16T b,
	input  wire sub,                        // 1 means a-b
	output logic decValid,
	input  wire decReady,
	output bfloatPkg::sigT bigSig,
	output bfloatPkg::sigT smallSig,
	output bfloatPkg::expT bigExp,
	output fpOpPkg::shiftT shift,
	output logic effSub,
	output logic sign,
	output fpOpPkg::specialT special,
	output logic invalid
);

	localparam int MAG_W = `EXP_WIDTH + `MANT_WIDTH;

	bfloatPkg::expT expA, expB;
	bfloatPkg::expT expSmall, expDiff;
	logic [`MANT_WIDTH-1:0] fracA, fracB;
	logic [MAG_W-1:0] magA, magB;
	bfloatPkg::sigT sigA, sigB;
	logic signA, signB;
	logic zeroA, zeroB, infA, infB, nanA, nanB;
	logic aBig;
	logic nextSign, nextInvalid;
	fpOpPkg::specialT nextSpecial;

	assign expA = a[MAG_W-1 -: `EXP_WIDTH];
	assign expB = b[MAG_W-1 -: `EXP_WIDTH];
	assign fracA = a[`MANT_WIDTH-1:0];
	assign fracB = b[`MANT_WIDTH-1:0];
	assign signA = a[MAG_W];
	assign signB = b[MAG_W] ^ sub;          // Subtract is add of negated b

	// Subnormals count as zero
	assign zeroA = (expA == '0);
	assign zeroB = (expB == '0);
	assign infA = (&expA) & ~(|fracA);
	assign infB = (&expB) & ~(|fracB);
	assign nanA = (&expA) & (|fracA);
	assign nanB = (&expB) & (|fracB);

	assign magA = zeroA ? '0 : a[MAG_W-1:0];
	assign magB = zeroB ? '0 : b[MAG_W-1:0];
	assign sigA = zeroA ? '0 : {1'b1, fracA};
	assign sigB = zeroB ? '0 : {1'b1, fracB};
	assign aBig = (magA >= magB);           // Exponent and fraction compare as one field

	assign expSmall = aBig ? expB : expA;
	assign expDiff = (aBig ? expA : expB) - expSmall;

	always_comb begin
		nextSpecial = fpOpPkg::SPEC_NONE;
		nextInvalid = 1'b0;
		nextSign = aBig ? signA : signB;    // Larger magnitude wins
		if (nanA || nanB) begin
			nextSpecial = fpOpPkg::SPEC_QNAN;
		end else if (infA && infB && (signA ^ signB)) begin
			nextSpecial = fpOpPkg::SPEC_QNAN; // inf - inf
			nextInvalid = 1'b1;
		end else if (infA || infB) begin
			nextSpecial = fpOpPkg::SPEC_INF;
			nextSign = infA ? signA : signB;
		end else if (zeroA && zeroB) begin
			nextSpecial = fpOpPkg::SPEC_ZERO;
			nextSign = signA & signB;       // Only -0 + -0 stays negative
		end
	end

	assign inReady = !decValid || decReady;

	always_ff @(posedge clk) begin
		if (reset) begin
			decValid <= 1'b0;
		end else if (inReady) begin
			decValid <= inValid;
		end
	end

	always_ff @(posedge clk) begin
		if (inValid && inReady) begin
			bigSig <= aBig ? sigA : sigB;
			smallSig <= aBig ? sigB : sigA;
			bigExp <= aBig ? expA : expB;
			shift <= (expDiff > fpOpPkg::SHIFT_MAX) ? fpOpPkg::SHIFT_MAX
				: fpOpPkg::shiftT'(expDiff);
			effSub <= signA ^ signB;
			sign <= nextSign;
			special <= nextSpecial;
			invalid <= nextInvalid;
		end
	end

	// Stalled payload must not move until execute takes it
	assert property (@(posedge clk) disable iff (reset)
		decValid && !decReady |=> decValid && $stable({bigSig, smallSig, bigExp, shift,
		effSub, sign, special, invalid}));

endmodule

`default_nettype wire

// ==== verilog/fpAddExecute.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "fp_config.svh"

module fpAddExecute (
	input  wire clk,
	input  wire reset,
	input  wire decValid,
	output logic decReady,
	input  wire bfloatPkg::sigT bigSig,
	input  wire bfloatPkg::sigT smallSig,
	input  wire bfloatPkg::expT bigExp,
	input  wire fpOpPkg::shiftT shift,
	input  wire effSub,
	input  wire decSign,
	input  wire fpOpPkg::specialT decSpecial,
	input  wire decInvalid,
	output logic exeValid,
	input  wire exeReady,
	output bfloatPkg::sumT sum,
	output bfloatPkg::expT exp,
	output logic sign,
	output fpOpPkg::specialT special,
	output logic invalid
);

	// Significand plus GRS positions
	localparam int ALIGN_W = $bits(bfloatPkg::sigT) + `GRS_BITS;

	logic [2*ALIGN_W-1:0] shifted;          // Upper half kept, lower half lost
	logic [ALIGN_W-1:0] aligned;
	bfloatPkg::sumT bigExt, smallExt, nextSum;
	logic nextSign;

	assign shifted = {smallSig, {`GRS_BITS{1'b0}}, {ALIGN_W{1'b0}}} >> shift;

	// Everything shifted off the end folds into sticky
	assign aligned = {shifted[2*ALIGN_W-1:ALIGN_W+1],
		shifted[ALIGN_W] | (|shifted[ALIGN_W-1:0])};

	assign bigExt = {1'b0, bigSig, {`GRS_BITS{1'b0}}};
	assign smallExt = {1'b0, aligned};

	// Big is never below small, so the difference stays positive
	assign nextSum = effSub ? bigExt - smallExt : bigExt + smallExt;

	// Exact cancellation gives +0
	assign nextSign = (decSpecial == fpOpPkg::SPEC_NONE && nextSum == '0) ? 1'b0 : decSign;

	assign decReady = !exeValid || exeReady;

	always_ff @(posedge clk) begin
		if (reset) begin
			exeValid <= 1'b0;
		end else if (decReady) begin
			exeValid <= decValid;
		end
	end

	always_ff @(posedge clk) begin
		if (decValid && decReady) begin
			sum <= nextSum;
			exp <= bigExp;                  // Normalize fixes it up later
			sign <= nextSign;
			special <= decSpecial;
			invalid <= decInvalid;
		end
	end

	// Decode saturates the distance
	assert property (@(posedge clk) disable iff (reset)
		decValid |-> shift <= fpOpPkg::SHIFT_MAX);

endmodule

`default_nettype wire

// ==== verilog/fpAddResult.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "fp_config.svh"

module fpAddResult (
	input  wire clk,
	input  wire reset,
	input  wire exeValid,
	output logic exeReady,
	input  wire bfloatPkg::sumT sum,
	input  wire bfloatPkg::expT exp,
	input  wire sign,
	input  wire fpOpPkg::specialT special,
	input  wire invalid,
	output logic outValid,
	input  wire outReady,
	output bfloatPkg::bf16T result,
	output fpOpPkg::flagsT flags
);

	localparam int SUM_TOP = $bits(bfloatPkg::sumT) - 1;   // Carry bit position
	localparam bfloatPkg::expWideT EXP_MAX = bfloatPkg::expWideT'(2 * `EXP_BIAS + 1);

	fpOpPkg::shiftT lz;                     // Leading zeros below the carry
	logic [SUM_TOP-1:0] norm;               // Hidden one, fraction, GRS
	bfloatPkg::expWideT expNorm, expRnd;
	logic [`MANT_WIDTH+1:0] rounded;        // Room for a rounding carry
	logic roundUp, expLow, sumZero;
	logic ovf, uf, inexact;
	bfloatPkg::bf16T nextResult;
	fpOpPkg::flagsT nextFlags;

	// Priority encoder, highest set bit wins
	always_comb begin
		lz = fpOpPkg::SHIFT_MAX;
		for (int i = 0; i < SUM_TOP; i++) begin
			if (sum[i]) begin
				lz = fpOpPkg::shiftT'(SUM_TOP - 1 - i);
			end
		end
	end

	always_comb begin
		if (sum[SUM_TOP]) begin
			norm = {sum[SUM_TOP:2], sum[1] | sum[0]};  // Right by one, keep sticky
			expNorm = {1'b0, exp} + 1'b1;
		end else begin
			norm = sum[SUM_TOP-1:0] << lz;
			expNorm = {1'b0, exp} - lz;
		end
	end

	assign sumZero = (sum == '0);
	assign expLow = !sum[SUM_TOP] && ({1'b0, exp} <= lz);    // Would land below 1

	// Round to nearest, ties to even
	assign roundUp = norm[`GRS_BITS-1] & ((|norm[`GRS_BITS-2:0]) | norm[`GRS_BITS]);
	assign rounded = {1'b0, norm[SUM_TOP-1:`GRS_BITS]} + roundUp;
	assign expRnd = expNorm + rounded[`MANT_WIDTH+1];   // 1.111 rounding up to 10.000

	assign uf = !sumZero && expLow;
	assign ovf = !sumZero && !expLow && (expRnd >= EXP_MAX);
	assign inexact = (|norm[`GRS_BITS-1:0]) | ovf | uf;

	always_comb begin
		case (special)
			fpOpPkg::SPEC_QNAN:
				nextResult = {1'b0, {`EXP_WIDTH{1'b1}}, 1'b1, {(`MANT_WIDTH-1){1'b0}}};
			fpOpPkg::SPEC_INF:
				nextResult = {sign, {`EXP_WIDTH{1'b1}}, {`MANT_WIDTH{1'b0}}};
			fpOpPkg::SPEC_ZERO:
				nextResult = {sign, {(`EXP_WIDTH+`MANT_WIDTH){1'b0}}};
			default: begin
				if (ovf) begin
					nextResult = {sign, {`EXP_WIDTH{1'b1}}, {`MANT_WIDTH{1'b0}}};
				end else if (uf || sumZero) begin
					nextResult = {sign, {(`EXP_WIDTH+`MANT_WIDTH){1'b0}}};  // Flush
				end else begin
					nextResult = {sign, expRnd[`EXP_WIDTH-1:0], rounded[`MANT_WIDTH-1:0]};
				end
			end
		endcase
	end

	// Special results are exact
	always_comb begin
		nextFlags = '0;
		nextFlags[fpOpPkg::FLAG_INVALID] = invalid;
		if (special == fpOpPkg::SPEC_NONE) begin
			nextFlags[fpOpPkg::FLAG_OVERFLOW] = ovf;
			nextFlags[fpOpPkg::FLAG_UNDERFLOW] = uf;
			nextFlags[fpOpPkg::FLAG_INEXACT] = inexact;
		end
	end

	assign exeReady = !outValid || outReady;

	always_ff @(posedge clk) begin
		if (reset) begin
			outValid <= 1'b0;
		end else if (exeReady) begin
			outValid <= exeValid;
		end
	end

	always_ff @(posedge clk) begin
		if (exeValid && exeReady) begin
			result <= nextResult;
			flags <= nextFlags;
		end
	end

	// Output held steady under back-pressure
	assert property (@(posedge clk) disable iff (reset)
		outValid && !outReady |=> outValid && $stable(result) && $stable(flags));

endmodule

`default_nettype wire

// ==== verilog/fpAddSub.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "fp_config.svh"

// Three stage bfloat16 add/sub with valid/ready on both sides
module fpAddSub (
	input  wire clk,
	input  wire reset,
	input  wire inValid,
	output logic inReady,
	input  wire bfloatPkg::bf16T a,
	input  wire bfloatPkg::bf16T b,
	input  wire sub,
	output logic outValid,
	input  wire outReady,
	output bfloatPkg::bf16T result,
	output fpOpPkg::flagsT flags
);

	// Decode to execute
	logic decValid, decReady;
	bfloatPkg::sigT bigSig, smallSig;
	bfloatPkg::expT bigExp;
	fpOpPkg::shiftT shift;
	logic effSub, decSign, decInvalid;
	fpOpPkg::specialT decSpecial;

	// Execute to result
	logic exeValid, exeReady;
	bfloatPkg::sumT exeSum;
	bfloatPkg::expT exeExp;
	logic exeSign, exeInvalid;
	fpOpPkg::specialT exeSpecial;

	fpAddDecode decode_i (
		.clk(clk), .reset(reset),
		.inValid(inValid), .inReady(inReady), .a(a), .b(b), .sub(sub),
		.decValid(decValid), .decReady(decReady),
		.bigSig(bigSig), .smallSig(smallSig), .bigExp(bigExp), .shift(shift),
		.effSub(effSub), .sign(decSign), .special(decSpecial), .invalid(decInvalid)
	);

	fpAddExecute execute_i (
		.clk(clk), .reset(reset),
		.decValid(decValid), .decReady(decReady),
		.bigSig(bigSig), .smallSig(smallSig), .bigExp(bigExp), .shift(shift),
		.effSub(effSub), .decSign(decSign), .decSpecial(decSpecial),
		.decInvalid(decInvalid),
		.exeValid(exeValid), .exeReady(exeReady),
		.sum(exeSum), .exp(exeExp), .sign(exeSign), .special(exeSpecial),
		.invalid(exeInvalid)
	);

	fpAddResult result_i (
		.clk(clk), .reset(reset),
		.exeValid(exeValid), .exeReady(exeReady),
		.sum(exeSum), .exp(exeExp), .sign(exeSign), .special(exeSpecial),
		.invalid(exeInvalid),
		.outValid(outValid), .outReady(outReady), .result(result), .flags(flags)
	);

endmodule

`default_nettype wire

// ==== test/fpAddSubChecker.sv ====
`timescale 1ns/1ps
`default_nettype none

// Watches both handshakes of the adder and compares against an exact model
module fpAddSubChecker (
	input  wire clk,
	input  wire reset,
	input  wire inValid,
	input  wire inReady,
	input  wire bfloatPkg::bf16T a,
	input  wire bfloatPkg::bf16T b,
	input  wire sub,
	input  wire outValid,
	input  wire outReady,
	input  wire bfloatPkg::bf16T result,
	input  wire fpOpPkg::flagsT flags,
	input  wire [127:0] testName,
	output int errorCount,
	output int inCount,
	output int outCount
);

	logic [19:0] expQ[$];                   // {flags, result} per accepted operation
	logic [32:0] opQ[$];                    // {a, b, sub} for the error line
	logic [19:0] expected;
	logic [32:0] op;

	// Exact sum on a 2^-133 grid, then round to nearest even
	function automatic logic [19:0] modelAddSub(input bfloatPkg::bf16T x,
		input bfloatPkg::bf16T y, input logic isSub);
		logic sx, sy, sr, zx, zy, ix, iy, nx, ny, roundUp;
		int ex, ey, p, e, i;
		logic [271:0] vx, vy, mag, rem, half, top;
		logic [8:0] mant;
		begin
			sx = x[15];
			sy = y[15] ^ isSub;             // a-b as a+(-b)
			ex = int'(x[14:7]);
			ey = int'(y[14:7]);
			zx = (ex == 0);                 // Subnormal is zero
			zy = (ey == 0);
			nx = (ex == 255) && (x[6:0] != 0);
			ny = (ey == 255) && (y[6:0] != 0);
			ix = (ex == 255) && (x[6:0] == 0);
			iy = (ey == 255) && (y[6:0] == 0);
			if (nx || ny)
				return {4'b0000, 16'h7FC0};
			if (ix && iy && (sx != sy))
				return {4'b0010, 16'h7FC0}; // inf-inf is invalid
			if (ix)
				return {4'b0000, sx, 8'hFF, 7'h00};
			if (iy)
				return {4'b0000, sy, 8'hFF, 7'h00};
			if (zx && zy)
				return {4'b0000, sx & sy, 15'h0000};
			vx = {264'd0, 1'b1, x[6:0]};
			vy = {264'd0, 1'b1, y[6:0]};
			vx = zx ? 272'd0 : vx << (ex - 1);
			vy = zy ? 272'd0 : vy << (ey - 1);
			if (sx == sy) begin
				mag = vx + vy;
				sr = sx;
			end else if (vx >= vy) begin
				mag = vx - vy;
				sr = sx;
			end else begin
				mag = vy - vx;
				sr = sy;
			end
			if (mag == 0)
				return {4'b0000, 16'h0000};  // Exact cancellation is +0
			p = 0;
			for (i = 0; i < 272; i++)
				if (mag[i])
					p = i;
			e = p - 6;                      // Biased exponent of the leading one
			if (e < 1)
				return {4'b0101, sr, 15'h0000};  // Flush below normal range
			rem = '0;
			roundUp = 1'b0;
			if (p >= 8) begin
				top = mag >> (p - 7);
				rem = mag & ((272'd1 << (p - 7)) - 272'd1);
				half = 272'd1 << (p - 8);
				roundUp = (rem > half) || ((rem == half) && top[0]);
			end else begin
				top = mag << (7 - p);
			end
			mant = {1'b0, top[7:0]} + {8'd0, roundUp};
			if (mant[8]) begin
				mant = 9'h080;              // 1.111.. rounded into next binade
				e = e + 1;
			end
			if (e >= 255)
				return {4'b1001, sr, 8'hFF, 7'h00};
			return {3'b000, rem != 0, sr, e[7:0], mant[6:0]};
		end
	endfunction

	always @(posedge clk) begin
		if (reset) begin
			expQ.delete();
			opQ.delete();
			errorCount = 0;
			inCount = 0;
			outCount = 0;
		end else begin
			// Pop before push so an early output cannot match its own input
			if (outValid && outReady) begin
				outCount++;
				if (expQ.size() == 0) begin
					$display("Error %0s: output transfer with no operation in flight", testName);
					errorCount++;
				end else begin
					expected = expQ.pop_front();
					op = opQ.pop_front();
					if ({flags, result} !== expected) begin
						$display("Fail %0s: a=%h b=%h sub=%b expected %h flags %b, actual %h flags %b",
							testName, op[32:17], op[16:1], op[0], expected[15:0],
							expected[19:16], result, flags);
						errorCount++;
					end
				end
			end
			if (inValid && inReady) begin
				expQ.push_back(modelAddSub(a, b, sub));
				opQ.push_back({a, b, sub});
				inCount++;
			end
		end
	end

endmodule

`default_nettype wire

// ==== test/fpAddSubTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module fpAddSubTb;

	localparam int NUM_RANDOM = 200;
	localparam int NUM_RANGE = 60;
	localparam int NUM_STREAM = 300;
	localparam int NUM_SPECIAL = 16;
	localparam int WAIT_LIMIT = 500;        // Cycles per wait loop

	logic clk, reset, inValid, sub, outReady, inReady, outValid;
	bfloatPkg::bf16T a, b, result;
	fpOpPkg::flagsT flags;
	logic [127:0] testName;
	int errorCount, inCount, outCount;
	int tbErrors, errStart, opStart;
	logic timedOut, stopToggle;
	logic [31:0] stimState, readyState;

	fpAddSub fpAddSub_i (
		.clk(clk), .reset(reset),
		.inValid(inValid), .inReady(inReady), .a(a), .b(b), .sub(sub),
		.outValid(outValid), .outReady(outReady), .result(result), .flags(flags)
	);

	fpAddSubChecker checker_i (
		.clk(clk), .reset(reset),
		.inValid(inValid), .inReady(inReady), .a(a), .b(b), .sub(sub),
		.outValid(outValid), .outReady(outReady), .result(result), .flags(flags),
		.testName(testName), .errorCount(errorCount), .inCount(inCount),
		.outCount(outCount)
	);

	always #10 clk = ~clk;                  // 20 ns period

	function automatic logic [31:0] lcgNext(input logic [31:0] state);
		return state * 32'd1103515245 + 32'd12345;
	endfunction

	function automatic logic [15:0] randStim();
		stimState = lcgNext(stimState);
		return stimState[30:15];            // Low LCG bits are weak
	endfunction

	// Normal operand with exponent from expLo up to expLo+span-1 and clamped to the normal range
	function automatic bfloatPkg::bf16T randNormal(input int expLo, input int span);
		logic [15:0] r;
		int e;
		r = randStim();
		e = expLo + int'(r[15:8]) % span;
		if (e < 1)
			e = 1;
		if (e > 254)
			e = 254;
		return {r[0], e[7:0], r[7:1]};
	endfunction

	// Fixed corner operands {a, b, sub}
	function automatic logic [32:0] specialOp(input int idx);
		case (idx)
			0: return {16'h7FC1, 16'h3F80, 1'b0};   // NaN operand
			1: return {16'h3F80, 16'hFF81, 1'b0};
			2: return {16'h7F80, 16'h3F80, 1'b0};   // Single inf
			3: return {16'h7F80, 16'h7F80, 1'b1};   // inf-inf
			4: return {16'h7F80, 16'hFF80, 1'b0};
			5: return {16'hFF80, 16'h4000, 1'b0};
			6: return {16'h7F80, 16'h7F80, 1'b0};
			7: return {16'h0000, 16'h0000, 1'b0};   // Zero sign rules
			8: return {16'h8000, 16'h8000, 1'b0};
			9: return {16'h8000, 16'h0000, 1'b1};
			10: return {16'h0000, 16'h0000, 1'b1};
			11: return {16'h0040, 16'h3F80, 1'b0};  // Subnormal as zero
			12: return {16'h8001, 16'h0012, 1'b0};
			13: return {16'h3F80, 16'h3F80, 1'b1};  // Exact cancellation
			14: return {16'hBF80, 16'h3F80, 1'b0};
			default: return {16'h7F80, 16'h0040, 1'b1};
		endcase
	endfunction

	task automatic sendOp(input bfloatPkg::bf16T opA, input bfloatPkg::bf16T opB,
		input logic opSub);
		int waited;
		logic taken;
		begin
			if (!timedOut) begin
				@(negedge clk);
				inValid = 1'b1;
				a = opA;
				b = opB;
				sub = opSub;
				waited = 0;
				taken = 1'b0;
				while (!taken && !timedOut) begin
					@(posedge clk);
					if (inReady) begin
						taken = 1'b1;
					end else begin
						waited++;
						if (waited > WAIT_LIMIT) begin
							$display("Timeout in %0s: inReady stayed low too long", testName);
							timedOut = 1'b1;
							tbErrors++;
						end
					end
				end
			end
		end
	endtask

	// Idle the input, then wait until every accepted operation came out
	task automatic drainOutputs();
		int waited;
		begin
			@(negedge clk);
			inValid = 1'b0;
			waited = 0;
			while (inCount != outCount && !timedOut) begin
				@(negedge clk);
				waited++;
				if (waited > WAIT_LIMIT) begin
					$display("Timeout in %0s: results did not drain", testName);
					timedOut = 1'b1;
					tbErrors++;
				end
			end
		end
	endtask

	task automatic startTest(input logic [127:0] name);
		testName = name;
		errStart = errorCount + tbErrors;
		opStart = inCount;
	endtask

	task automatic finishTest();
		drainOutputs();
		$display("Test %0s: %0d operations, %0d errors", testName, inCount - opStart,
			errorCount + tbErrors - errStart);
	endtask

	initial begin
		logic [15:0] r;
		bfloatPkg::bf16T x, y;
		logic [32:0] sp;
		clk = 1'b0;
		reset = 1'b1;
		inValid = 1'b0;
		a = '0;
		b = '0;
		sub = 1'b0;
		outReady = 1'b1;
		testName = "reset";
		tbErrors = 0;
		timedOut = 1'b0;
		stopToggle = 1'b0;
		stimState = 32'd1271;
		repeat (5) @(posedge clk);
		@(negedge clk) reset = 1'b0;

		startTest("reset");
		repeat (5) begin
			@(negedge clk);
			if (outValid !== 1'b0) begin
				$display("Error reset: outValid not low after reset with no input");
				tbErrors++;
			end
		end
		finishTest();

		startTest("randomAdd");
		for (int i = 0; i < NUM_RANDOM; i++) begin
			x = randNormal(100, 56);
			r = randStim();
			y = r[0] ? randNormal(int'(x[14:7]) - 10, 21) : randNormal(1, 254);
			sendOp(x, y, 1'b0);
		end
		finishTest();

		startTest("randomSub");
		for (int i = 0; i < NUM_RANDOM; i++) begin
			x = randNormal(100, 56);
			r = randStim();
			y = (r[2:0] == 0) ? x : randNormal(int'(x[14:7]) - 1, 3);
			y[15] = x[15];                  // Same sign so sub cancels
			sendOp(x, y, 1'b1);
		end
		finishTest();

		startTest("special");
		for (int i = 0; i < NUM_SPECIAL; i++) begin
			sp = specialOp(i);
			sendOp(sp[32:17], sp[16:1], sp[0]);
		end
		finishTest();

		startTest("range");
		sendOp(16'h7F7F, 16'h7F7F, 1'b0);   // Max plus max
		sendOp(16'h0081, 16'h0080, 1'b1);   // Lands below 2^-126
		for (int i = 0; i < NUM_RANGE; i++) begin
			if (i % 2 == 0) begin
				x = randNormal(252, 3);
				y = randNormal(252, 3);
			end else begin
				x = randNormal(1, 2);
				y = randNormal(1, 2);
			end
			y[15] = x[15];
			sendOp(x, y, i % 2 == 1);
		end
		finishTest();

		startTest("backPressure");
		readyState = lcgNext(stimState ^ 32'h5A5A5A5A);   // Own stream for outReady
		fork
			begin
				for (int i = 0; i < NUM_STREAM; i++) begin
					x = randStim();
					y = randStim();
					r = randStim();
					sendOp(x, y, r[4]);
				end
				stopToggle = 1'b1;
			end
			begin
				while (!stopToggle) begin
					@(negedge clk);
					readyState = lcgNext(readyState);
					outReady = readyState[29];
				end
			end
		join
		@(negedge clk) outReady = 1'b1;
		finishTest();
		if (inCount != outCount) begin
			$display("Error backPressure: %0d operations in but %0d results out",
				inCount, outCount);
			tbErrors++;
		end

		$display("Summary: %0d operations in, %0d results out, %0d errors", inCount, outCount,
			errorCount + tbErrors);
		if (errorCount + tbErrors == 0 && !timedOut)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+verilog
verilog/bfloatPkg.sv
verilog/fpOpPkg.sv
verilog/fpAddDecode.sv
verilog/fpAddExecute.sv
verilog/fpAddResult.sv
verilog/fpAddSub.sv
test/fpAddSubChecker.sv
test/fpAddSubTb.sv

// ==== Bender.yml ====
package:
  name: fp_add_sub

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/bfloatPkg.sv
      - verilog/fpOpPkg.sv
      - verilog/fpAddDecode.sv
      - verilog/fpAddExecute.sv
      - verilog/fpAddResult.sv
      - verilog/fpAddSub.sv
  - target: test
    files:
      - test/fpAddSubChecker.sv
      - test/fpAddSubTb.sv
